/* tb.f */
+incdir+hdl
+incdir+test
hdl/apg_reg_pkg.sv
hdl/apg_core_pkg.sv
hdl/axi4lite_slave.sv
hdl/apg_regs.sv
hdl/apg_engine.sv
hdl/apg_top.sv
test/tb_apg.sv

/* test/tb_apg_model.svh */
`ifndef TB_APG_MODEL_SVH
`define TB_APG_MODEL_SVH

////////////////////////////////////////
// Reference model of the pattern engine
////////////////////////////////////////

// Samples as software loaded them, low NUM_SIG bits only
logic [`APG_NUM_SIG-1:0] ref_pat [`APG_NUM_SAMP];

// k-th sample on output_signals, playback wraps over the loaded length
function automatic logic [31:0] played_sample(input int k, input int len);
  return 32'(ref_pat[k % len]);
endfunction

// Capture stops once the buffer is full
function automatic int captured_count(input int n_samp);
  if (n_samp < `APG_NUM_SAMP) begin
    return n_samp;
  end
  return `APG_NUM_SAMP;
endfunction

// k-th pop of read_channel, zero past the captured count
function automatic logic [31:0] popped_sample(input int k, input int n_samp, input int len);
  if (k < captured_count(n_samp)) begin
    return played_sample(k, len);
  end
  return 32'h0;
endfunction

// sample_count after a finished playback of n_samp cycles
function automatic logic [31:0] sample_total(input int n_samp);
  return 32'(n_samp);
endfunction

// wave_ptr after n_samp advances
function automatic logic [31:0] wrapped_ptr(input int n_samp, input int len);
  return 32'(n_samp % len);
endfunction

// Status word layout
function automatic logic [31:0] status_word(input logic running, input logic done,
                                            input logic error);
  // error bit 2, done bit 1, running bit 0
  return {29'h0, error, done, running};
endfunction

`endif

/* test/tb_apg.sv */
`timescale 1ns/1ps
`include "apg_defines.svh"

module tb_apg
  import apg_reg_pkg::*;
();

  // Cycles allowed for any single AXI wait
  localparam int timeout_cyc = 50;
  // Loaded pattern length and playback length
  localparam int pat_len = 20;
  localparam int n_play  = 53;

  logic                     S_AXI_ACLK, S_AXI_ARESETN;
  logic [`APG_ADDR_W-1:0]   S_AXI_AWADDR, S_AXI_ARADDR;
  logic [2:0]               S_AXI_AWPROT, S_AXI_ARPROT;
  logic                     S_AXI_AWVALID, S_AXI_AWREADY, S_AXI_WVALID, S_AXI_WREADY;
  logic [`APG_DATA_W-1:0]   S_AXI_WDATA, S_AXI_RDATA;
  logic [`APG_DATA_W/8-1:0] S_AXI_WSTRB;
  logic [1:0]               S_AXI_BRESP, S_AXI_RRESP;
  logic                     S_AXI_BVALID, S_AXI_BREADY;
  logic                     S_AXI_ARVALID, S_AXI_ARREADY, S_AXI_RVALID, S_AXI_RREADY;
  logic [`APG_NUM_SIG-1:0]  output_signals, input_signals;

  integer      seed;
  logic [31:0] rd;

  `include "tb_apg_model.svh"

  // Loopback so every played sample is captured again
  assign input_signals = output_signals;

  apg_top i_apg_top (.*);

  // 40 ns clock
  initial begin
    S_AXI_ACLK = 1'b0;
    forever #20 S_AXI_ACLK = ~S_AXI_ACLK;
  end

  ////////////////////////////////////////
  // Failure reporting and checks
  ////////////////////////////////////////

  task automatic give_up(input string what);
    $display("Timeout: %s", what);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////
  // AXI4-Lite bus tasks
  ////////////////////////////////////////

  task automatic write_reg(input reg_addr_e addr, input logic [31:0] data);
    int cnt;
    @(posedge S_AXI_ACLK);
    S_AXI_AWADDR  <= `APG_ADDR_W'({addr, 2'b00});
    S_AXI_WDATA   <= data;
    S_AXI_WSTRB   <= 4'hF;
    S_AXI_AWVALID <= 1'b1;
    S_AXI_WVALID  <= 1'b1;
    cnt = 0;
    // Address and data are accepted together
    do begin
      @(posedge S_AXI_ACLK);
      cnt++;
      if (cnt > timeout_cyc) give_up("write address and data never accepted");
    end while (!(S_AXI_AWREADY && S_AXI_WREADY));
    S_AXI_AWVALID <= 1'b0;
    S_AXI_WVALID  <= 1'b0;
    S_AXI_BREADY  <= 1'b1;
    cnt = 0;
    do begin
      @(posedge S_AXI_ACLK);
      cnt++;
      if (cnt > timeout_cyc) give_up("write response never arrived");
    end while (!S_AXI_BVALID);
    // Write responses are always OKAY
    check_value("S_AXI_BRESP", 32'(S_AXI_BRESP), 32'h0);
    S_AXI_BREADY <= 1'b0;
    // Strobe passes the register bank and then the engine
    repeat (2) @(posedge S_AXI_ACLK);
  endtask

  task automatic read_reg(input reg_addr_e addr, output logic [31:0] data);
    int cnt;
    @(posedge S_AXI_ACLK);
    S_AXI_ARADDR  <= `APG_ADDR_W'({addr, 2'b00});
    S_AXI_ARVALID <= 1'b1;
    cnt = 0;
    do begin
      @(posedge S_AXI_ACLK);
      cnt++;
      if (cnt > timeout_cyc) give_up("read address never accepted");
    end while (!S_AXI_ARREADY);
    S_AXI_ARVALID <= 1'b0;
    S_AXI_RREADY  <= 1'b1;
    cnt = 0;
    do begin
      @(posedge S_AXI_ACLK);
      cnt++;
      if (cnt > timeout_cyc) give_up("read data never arrived");
    end while (!S_AXI_RVALID);
    // Read responses are always OKAY
    check_value("S_AXI_RRESP", 32'(S_AXI_RRESP), 32'h0);
    data = S_AXI_RDATA;
    S_AXI_RREADY <= 1'b0;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int          polls;
    logic [31:0] word;
    seed          = 18881;
    S_AXI_ARESETN = 1'b0;
    S_AXI_AWADDR  = '0;
    S_AXI_AWPROT  = '0;
    S_AXI_AWVALID = 1'b0;
    S_AXI_WDATA   = '0;
    S_AXI_WSTRB   = '0;
    S_AXI_WVALID  = 1'b0;
    S_AXI_BREADY  = 1'b0;
    S_AXI_ARADDR  = '0;
    S_AXI_ARPROT  = '0;
    S_AXI_ARVALID = 1'b0;
    S_AXI_RREADY  = 1'b0;
    repeat (10) @(posedge S_AXI_ACLK);
    S_AXI_ARESETN <= 1'b1;

    // Quiet state after reset
    check_value("output_signals", 32'(output_signals), 32'h0);
    read_reg(addr_status, rd);
    check_value("status", rd, status_word(1'b0, 1'b0, 1'b0));
    read_reg(addr_write_buffer_len, rd);
    check_value("write_buffer_len", rd, 32'h0);
    read_reg(addr_sample_count, rd);
    check_value("sample_count", rd, 32'h0);
    read_reg(addr_dbg_error, rd);
    check_value("dbg_error", rd, 32'h0);
    write_reg(addr_n_samples, 32'hDEAD_BEEF);
    read_reg(addr_n_samples, rd);
    check_value("n_samples", rd, 32'hDEAD_BEEF);
    // Bit 0 stays clear for one-shot playback
    write_reg(addr_control, 32'h0000_5AF0);
    read_reg(addr_control, rd);
    check_value("control", rd, 32'h0000_5AF0);

    // Load the pattern with only the low NUM_SIG bits kept
    for (int i = 0; i < pat_len; i++) begin
      word = $random(seed);
      ref_pat[i] = word[`APG_NUM_SIG-1:0];
      write_reg(addr_write_channel, word);
    end
    read_reg(addr_write_buffer_len, rd);
    check_value("write_buffer_len", rd, 32'(pat_len));

    // One-shot playback longer than the pattern
    write_reg(addr_n_samples, 32'(n_play));
    write_reg(addr_run, 32'h1);
    polls = 0;
    do begin
      read_reg(addr_status, rd);
      polls++;
      if (polls > 100) give_up("playback never reached done");
    end while (!rd[1]);
    check_value("status", rd, status_word(1'b0, 1'b1, 1'b0));
    read_reg(addr_sample_count, rd);
    check_value("sample_count", rd, sample_total(n_play));
    read_reg(addr_wave_ptr, rd);
    check_value("wave_ptr", rd, wrapped_ptr(n_play, pat_len));

    // Drain the capture buffer
    for (int k = 0; k < n_play; k++) begin
      read_reg(addr_read_channel, rd);
      check_value("read_channel", rd, popped_sample(k, n_play, pat_len));
    end
    read_reg(addr_next_read_sample, rd);
    check_value("next_read_sample", rd, 32'(n_play));

    // Pop past the end is an error
    read_reg(addr_read_channel, rd);
    check_value("read_channel", rd, popped_sample(n_play, n_play, pat_len));
    read_reg(addr_status, rd);
    check_value("status", rd, status_word(1'b0, 1'b1, 1'b1));
    read_reg(addr_dbg_error, rd);
    check_value("dbg_error", rd, 32'h1);

    // Looping playback rejects new samples
    write_reg(addr_control, 32'h1);
    write_reg(addr_run, 32'h1);
    read_reg(addr_status, rd);
    check_value("status", rd, status_word(1'b1, 1'b0, 1'b1));
    write_reg(addr_write_channel, 32'h0000_1234);
    read_reg(addr_dbg_error, rd);
    check_value("dbg_error", rd, 32'h2);
    read_reg(addr_write_buffer_len, rd);
    check_value("write_buffer_len", rd, 32'(pat_len));

    // Clear stops the loop and zeroes the counters
    write_reg(addr_clear, 32'h1);
    check_value("output_signals", 32'(output_signals), 32'h0);
    read_reg(addr_status, rd);
    check_value("status", rd, status_word(1'b0, 1'b0, 1'b0));
    read_reg(addr_write_buffer_len, rd);
    check_value("write_buffer_len", rd, 32'h0);
    read_reg(addr_sample_count, rd);
    check_value("sample_count", rd, 32'h0);
    read_reg(addr_wave_ptr, rd);
    check_value("wave_ptr", rd, 32'h0);
    read_reg(addr_next_read_sample, rd);
    check_value("next_read_sample", rd, 32'h0);

    $display("sim passed");
    $finish;
  end

endmodule

/* hdl/apg_top.sv */
`timescale 1ns/1ps
`include "apg_defines.svh"

module apg_top
  import apg_reg_pkg::*, apg_core_pkg::*;
(
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  input  logic [`APG_ADDR_W-1:0]    S_AXI_AWADDR,
  input  logic [2:0]                S_AXI_AWPROT,
  input  logic                      S_AXI_AWVALID,
  output logic                      S_AXI_AWREADY,
  input  logic [`APG_DATA_W-1:0]    S_AXI_WDATA,
  input  logic [`APG_DATA_W/8-1:0]  S_AXI_WSTRB,
  input  logic                      S_AXI_WVALID,
  output logic                      S_AXI_WREADY,
  output logic [1:0]                S_AXI_BRESP,
  output logic                      S_AXI_BVALID,
  input  logic                      S_AXI_BREADY,
  input  logic [`APG_ADDR_W-1:0]    S_AXI_ARADDR,
  input  logic [2:0]                S_AXI_ARPROT,
  input  logic                      S_AXI_ARVALID,
  output logic                      S_AXI_ARREADY,
  output logic [`APG_DATA_W-1:0]    S_AXI_RDATA,
  output logic [1:0]                S_AXI_RRESP,
  output logic                      S_AXI_RVALID,
  input  logic                      S_AXI_RREADY,
  output logic [`APG_NUM_SIG-1:0]   output_signals,
  input  logic [`APG_NUM_SIG-1:0]   input_signals
);

  // Bus side to register bank
  reg_wr_s   reg_wr;
  reg_rd_s   reg_rd;
  word_t     rd_word;

  // Register bank to engine and back
  apg_ctrl_s ctrl;
  apg_stat_s stat;

  axi4lite_slave i_axi4lite_slave (.*);

  apg_regs i_apg_regs (.*);

  apg_engine i_apg_engine (.*);

endmodule

/* hdl/apg_engine.sv */
`timescale 1ns/1ps
`include "apg_defines.svh"

module apg_engine
  import apg_core_pkg::*;
(
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  input  apg_ctrl_s               ctrl,
  output apg_stat_s               stat,
  output logic [`APG_NUM_SIG-1:0] output_signals,
  input  logic [`APG_NUM_SIG-1:0] input_signals
);

  localparam int ptr_w = $clog2(`APG_NUM_SAMP);

  // Pattern and capture buffers
  logic [`APG_NUM_SIG-1:0] pat_mem [`APG_NUM_SAMP];
  logic [`APG_NUM_SIG-1:0] cap_mem [`APG_NUM_SAMP];

  eng_state_e     state;
  // Buffer fill levels and read pointer need one extra bit for a full buffer
  logic [ptr_w:0] wr_len, cap_cnt, rd_ptr;
  logic [ptr_w-1:0] wave_ptr;
  cnt_t           samp_cnt, dbg_err;
  logic           err_flag;

  logic playing, rd_avail, push_ok, bad_push, pop_ok, bad_pop, bad_run;
  logic cap_en, last_samp;

  always_comb begin
    playing   = (state == eng_play);
    rd_avail  = (rd_ptr < cap_cnt);
    // No loading while playing or once full
    push_ok   = ctrl.push && !playing && (wr_len < `APG_NUM_SAMP);
    bad_push  = ctrl.push && !push_ok;
    pop_ok    = ctrl.pop && rd_avail;
    bad_pop   = ctrl.pop && !rd_avail;
    bad_run   = ctrl.run && (wr_len == '0);
    cap_en    = playing && (cap_cnt < `APG_NUM_SAMP);
    last_samp = !ctrl.loop && (samp_cnt + 1'b1 >= ctrl.n_samples);
  end

  ////////////////////////////////////////
  // Sequencer and counters
  ////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    // Clear brings everything back to the reset state
    if (!S_AXI_ARESETN || ctrl.clear) begin
      state    <= eng_idle;
      wr_len   <= '0;
      cap_cnt  <= '0;
      rd_ptr   <= '0;
      wave_ptr <= '0;
      samp_cnt <= '0;
      dbg_err  <= '0;
      err_flag <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_len <= wr_len + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (bad_push || bad_pop || bad_run) begin
        err_flag <= 1'b1;
      end
      dbg_err <= dbg_err + cnt_t'(bad_push) + cnt_t'(bad_pop) + cnt_t'(bad_run);
      // Run also restarts an active playback
      if (ctrl.run && !bad_run) begin
        state    <= (ctrl.n_samples == '0 && !ctrl.loop) ? eng_done : eng_play;
        wave_ptr <= '0;
        samp_cnt <= '0;
        cap_cnt  <= '0;
        rd_ptr   <= '0;
      end else if (playing) begin
        // Wrap over the loaded length
        if ({1'b0, wave_ptr} + 1'b1 == wr_len) begin
          wave_ptr <= '0;
        end else begin
          wave_ptr <= wave_ptr + 1'b1;
        end
        samp_cnt <= samp_cnt + 1'b1;
        if (cap_en) begin
          cap_cnt <= cap_cnt + 1'b1;
        end
        if (last_samp) begin
          state <= eng_done;
        end
      end
    end
  end

  // Buffer writes
  always_ff @(posedge S_AXI_ACLK) begin
    if (push_ok) begin
      pat_mem[wr_len[ptr_w-1:0]] <= ctrl.push_data;
    end
    if (cap_en) begin
      cap_mem[cap_cnt[ptr_w-1:0]] <= input_signals;
    end
  end

  // Sample is on the pins in the same cycle it gets captured
  assign output_signals = playing ? pat_mem[wave_ptr] : '0;

  always_comb begin
    stat.running          = playing;
    stat.done             = (state == eng_done);
    stat.error            = err_flag;
    stat.write_buffer_len = cnt_t'(wr_len);
    stat.sample_count     = samp_cnt;
    stat.wave_ptr         = cnt_t'(wave_ptr);
    stat.next_read_sample = cnt_t'(rd_ptr);
    // Zero past the captured count
    stat.rd_data          = rd_avail ? cap_mem[rd_ptr[ptr_w-1:0]] : '0;
    stat.dbg_error        = dbg_err;
  end

endmodule

/* hdl/apg_regs.sv */
`timescale 1ns/1ps
`include "apg_defines.svh"

module apg_regs
  import apg_reg_pkg::*, apg_core_pkg::*;
(
  input  logic      S_AXI_ACLK,
  input  logic      S_AXI_ARESETN,
  input  reg_wr_s   reg_wr,
  input  reg_rd_s   reg_rd,
  output word_t     rd_word,
  output apg_ctrl_s ctrl,
  input  apg_stat_s stat
);

  logic                    wr_hit;
  logic                    run_q, clear_q, push_q;
  logic [`APG_NUM_SIG-1:0] wr_chan_q;
  word_t                   n_samp_q;
  word_t                   control_q;

  // Only full-word writes count
  assign wr_hit = reg_wr.valid && reg_wr.full_strb;

  ////////////////////////////////////////
  // Software registers
  ////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      run_q     <= 1'b0;
      clear_q   <= 1'b0;
      push_q    <= 1'b0;
      wr_chan_q <= '0;
      n_samp_q  <= '0;
      control_q <= '0;
    end else begin
      // Strobes last one cycle
      run_q   <= wr_hit && (reg_wr.addr == addr_run);
      clear_q <= wr_hit && (reg_wr.addr == addr_clear);
      push_q  <= wr_hit && (reg_wr.addr == addr_write_channel);
      if (wr_hit && reg_wr.addr == addr_write_channel) begin
        wr_chan_q <= reg_wr.data[`APG_NUM_SIG-1:0];
      end
      if (wr_hit && reg_wr.addr == addr_n_samples) begin
        n_samp_q <= reg_wr.data;
      end
      if (wr_hit && reg_wr.addr == addr_control) begin
        control_q <= reg_wr.data;
      end
    end
  end

  // Engine control
  always_comb begin
    ctrl.run       = run_q;
    ctrl.clear     = clear_q;
    ctrl.push      = push_q;
    ctrl.push_data = wr_chan_q;
    // Pop lands in the AR handshake cycle
    ctrl.pop       = reg_rd.valid && (reg_rd.addr == addr_read_channel);
    ctrl.n_samples = n_samp_q;
    // Bit 0 selects continuous looping
    ctrl.loop      = control_q[0];
  end

  ////////////////////////////////////////
  // Read-back multiplexer
  ////////////////////////////////////////

  always_comb begin
    case (reg_rd.addr)
      addr_run:              rd_word = word_t'(run_q);
      addr_write_channel:    rd_word = word_t'(wr_chan_q);
      addr_read_channel:     rd_word = word_t'(stat.rd_data);
      addr_sample_count:     rd_word = stat.sample_count;
      addr_n_samples:        rd_word = n_samp_q;
      addr_control:          rd_word = control_q;
      addr_write_buffer_len: rd_word = stat.write_buffer_len;
      addr_next_read_sample: rd_word = stat.next_read_sample;
      addr_wave_ptr:         rd_word = stat.wave_ptr;
      // Error, done, running from bit 2 down
      addr_status:           rd_word = word_t'({stat.error, stat.done, stat.running});
      addr_clear:            rd_word = word_t'(clear_q);
      addr_dbg_error:        rd_word = stat.dbg_error;
      default:               rd_word = '0;
    endcase
  end

endmodule

/* hdl/axi4lite_slave.sv */
`timescale 1ns/1ps
`include "apg_defines.svh"

module axi4lite_slave
  import apg_reg_pkg::*;
(
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  input  logic [`APG_ADDR_W-1:0]    S_AXI_AWADDR,
  // Protection bits are not decoded
  input  logic [2:0]                S_AXI_AWPROT,
  input  logic                      S_AXI_AWVALID,
  output logic                      S_AXI_AWREADY,
  input  logic [`APG_DATA_W-1:0]    S_AXI_WDATA,
  input  logic [`APG_DATA_W/8-1:0]  S_AXI_WSTRB,
  input  logic                      S_AXI_WVALID,
  output logic                      S_AXI_WREADY,
  output logic [1:0]                S_AXI_BRESP,
  output logic                      S_AXI_BVALID,
  input  logic                      S_AXI_BREADY,
  input  logic [`APG_ADDR_W-1:0]    S_AXI_ARADDR,
  input  logic [2:0]                S_AXI_ARPROT,
  input  logic                      S_AXI_ARVALID,
  output logic                      S_AXI_ARREADY,
  output logic [`APG_DATA_W-1:0]    S_AXI_RDATA,
  output logic [1:0]                S_AXI_RRESP,
  output logic                      S_AXI_RVALID,
  input  logic                      S_AXI_RREADY,
  output reg_wr_s                   reg_wr,
  output reg_rd_s                   reg_rd,
  input  word_t                     rd_word
);

  // Byte offset below the word index
  localparam int addr_lsb = $clog2(`APG_DATA_W / 8);
  localparam int idx_w    = $bits(reg_addr_e);

  logic      wr_rdy, wr_hs, wr_valid_q, wr_full_q, bvalid_q;
  reg_addr_e wr_addr_q;
  word_t     wr_data_q;
  logic      rd_rdy, rd_hs, rvalid_q;
  word_t     rdata_q;

  // Address and data are taken together in one handshake
  assign wr_hs = wr_rdy && S_AXI_AWVALID && S_AXI_WVALID;
  assign rd_hs = rd_rdy && S_AXI_ARVALID;

  assign S_AXI_AWREADY = wr_rdy;
  assign S_AXI_WREADY  = wr_rdy;
  assign S_AXI_BVALID  = bvalid_q;
  // Always OKAY
  assign S_AXI_BRESP   = 2'b00;
  assign S_AXI_ARREADY = rd_rdy;
  assign S_AXI_RVALID  = rvalid_q;
  assign S_AXI_RDATA   = rdata_q;
  assign S_AXI_RRESP   = 2'b00;

  assign reg_wr = '{valid: wr_valid_q, full_strb: wr_full_q, addr: wr_addr_q, data: wr_data_q};
  // Read request goes out in the handshake cycle
  assign reg_rd = '{valid: rd_hs, addr: reg_addr_e'(S_AXI_ARADDR[addr_lsb +: idx_w])};

  ////////////////////////////////////////
  // Write channel
  ////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      wr_rdy     <= 1'b0;
      wr_valid_q <= 1'b0;
      bvalid_q   <= 1'b0;
    end else begin
      // One-cycle ready pulse, held off while a response waits
      wr_rdy     <= !wr_rdy && !bvalid_q && S_AXI_AWVALID && S_AXI_WVALID;
      wr_valid_q <= wr_hs;
      if (wr_hs) begin
        bvalid_q <= 1'b1;
      end else if (S_AXI_BREADY) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Read channel
  ////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      rd_rdy   <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      rd_rdy <= !rd_rdy && !rvalid_q && S_AXI_ARVALID;
      if (rd_hs) begin
        rvalid_q <= 1'b1;
      end else if (S_AXI_RREADY) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Payload registers
  always_ff @(posedge S_AXI_ACLK) begin
    if (wr_hs) begin
      wr_addr_q <= reg_addr_e'(S_AXI_AWADDR[addr_lsb +: idx_w]);
      wr_data_q <= S_AXI_WDATA;
      wr_full_q <= &S_AXI_WSTRB;
    end
    // Read-back word is sampled once per accepted read
    if (rd_hs) begin
      rdata_q <= rd_word;
    end
  end

endmodule

/* hdl/apg_core_pkg.sv */
`include "apg_defines.svh"

package apg_core_pkg;

  // Counter and length values as seen by software
  typedef logic [`APG_DATA_W-1:0] cnt_t;

  // Sequencer states
  typedef enum logic [1:0] {
    eng_idle = 2'd0,
    eng_play = 2'd1,
    eng_done = 2'd2
  } eng_state_e;

  // Register bank to engine
  typedef struct packed {
    logic                    run;
    logic                    clear;
    logic                    push;
    logic [`APG_NUM_SIG-1:0] push_data;
    logic                    pop;
    cnt_t                    n_samples;
    logic                    loop;
  } apg_ctrl_s;

  // Engine to register bank
  typedef struct packed {
    logic                    running;
    logic                    done;
    logic                    error;
    cnt_t                    write_buffer_len;
    cnt_t                    sample_count;
    cnt_t                    wave_ptr;
    cnt_t                    next_read_sample;
    logic [`APG_NUM_SIG-1:0] rd_data;
    cnt_t                    dbg_error;
  } apg_stat_s;

endpackage

/* hdl/apg_reg_pkg.sv */
`include "apg_defines.svh"

package apg_reg_pkg;

  // One bus word
  typedef logic [`APG_DATA_W-1:0] word_t;

  ////////////////////////////////////////
  // Register map, word indices
  ////////////////////////////////////////

  // Byte address is the index times four
  typedef enum logic [$clog2(`APG_REG_N)-1:0] {
    addr_run              = 4'd0,
    addr_write_channel    = 4'd1,
    addr_read_channel     = 4'd2,
    addr_sample_count     = 4'd3,
    addr_n_samples        = 4'd4,
    addr_control          = 4'd5,
    addr_write_buffer_len = 4'd6,
    addr_next_read_sample = 4'd7,
    addr_wave_ptr         = 4'd8,
    addr_status           = 4'd9,
    addr_clear            = 4'd10,
    addr_dbg_error        = 4'd11
  } reg_addr_e;

  // Write request, valid for a single cycle
  typedef struct packed {
    logic      valid;
    // All four byte lanes enabled
    logic      full_strb;
    reg_addr_e addr;
    word_t     data;
  } reg_wr_s;

  // Read request, valid in the AR handshake cycle
  typedef struct packed {
    logic      valid;
    reg_addr_e addr;
  } reg_rd_s;

endpackage

/* hdl/apg_defines.svh */
`ifndef APG_DEFINES_SVH
`define APG_DEFINES_SVH

////////////////////////////////////////
// Pattern generator sizing
////////////////////////////////////////

// Width of one pattern sample
`define APG_NUM_SIG 14

// Depth of the pattern and capture buffers, a power of two
`define APG_NUM_SAMP 128

////////////////////////////////////////
// AXI4-Lite bus sizing
////////////////////////////////////////

`define APG_DATA_W 32
`define APG_ADDR_W 11

// Number of software-visible registers
`define APG_REG_N 12

`endif
